//--- hw/fcmp_macros.svh
`ifndef FCMP_MACROS_SVH
`define FCMP_MACROS_SVH

// register and integer result widths
`define FLEN 64
`define XLEN 64

// double fields
`define NE 11
`define NF 52

// single fields, boxed in the upper half of the register
`define NE1 8
`define NF1 23
`define LEN1 32

// fmt input
`define FMT_S 1'b0
`define FMT_D 1'b1

// opCtrl codes, bit 2 marks min/max
`define OP_MIN 3'b110
`define OP_MAX 3'b101
`define OP_EQ 3'b010
`define OP_LT 3'b001
`define OP_LE 3'b011

`define QNAN_D 64'h7FF8000000000000 // canonical double qnan
`define QNAN_S 64'hFFFFFFFF7FC00000 // canonical single qnan, nan-boxed

`endif

//--- hw/fcmpPkg.sv
`default_nettype none

`include "fcmp_macros.svh"

package fcmpPkg;

   // one fp register word, read as double or as boxed single
   typedef union packed {
      struct packed {
         logic sgn;
         logic [`NE-1:0] exp;
         logic [`NF-1:0] frac;
      } d; // double view
      struct packed {
         logic [`FLEN-`LEN1-1:0] box; // all ones when properly boxed
         logic sgn;
         logic [`NE1-1:0] exp;
         logic [`NF1-1:0] frac;
      } s; // single view
   } fpWordT;

endpackage

`default_nettype wire

//--- hw/fpUnpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_macros.svh"

module fpUnpack (
   input  wire logic           clk,
   input  wire logic           arstN,
   input  wire logic           inValid,   // one op per strobe
   input  wire logic           fmt,       // 1 double, 0 single
   input  wire logic [2:0]     opCtrl,
   input  wire fcmpPkg::fpWordT srcX,
   input  wire fcmpPkg::fpWordT srcY,
   output logic                exeValid,
   output logic                exeFmt,
   output logic [2:0]          exeOp,
   output logic                xSgn,
   output logic                ySgn,
   output logic [`NE-1:0]      xExp,
   output logic [`NE-1:0]      yExp,
   output logic [`NF:0]        xMan,      // hidden bit on top
   output logic [`NF:0]        yMan,
   output logic                xZero,
   output logic                yZero,
   output logic                xNaN,
   output logic                yNaN,
   output logic                xSNaN,
   output logic                ySNaN,
   output fcmpPkg::fpWordT     xSrc,      // after nan-box substitution
   output fcmpPkg::fpWordT     ySrc
);

   // index 0 is x, 1 is y
   fcmpPkg::fpWordT                word [2];
   logic [1:0]                     sgnC;
   logic [1:0][`NE-1:0]            expC;
   logic [1:0][`NF-1:0]            fracC;
   logic [1:0]                     expOnes;   // inf or nan exponent
   logic [1:0]                     nanC;

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         word[i] = (i == 0) ? srcX : srcY;
         // bad box reads as canonical qnan
         if (fmt == `FMT_S && word[i].s.box != '1)
            word[i] = `QNAN_S;
         if (fmt == `FMT_D) begin
            sgnC[i]    = word[i].d.sgn;
            expC[i]    = word[i].d.exp;
            fracC[i]   = word[i].d.frac;
            expOnes[i] = &word[i].d.exp;
         end else begin
            sgnC[i]    = word[i].s.sgn;
            expC[i]    = {{(`NE-`NE1){1'b0}}, word[i].s.exp}; // zero-extend keeps order
            fracC[i]   = {word[i].s.frac, {(`NF-`NF1){1'b0}}}; // left-aligned
            expOnes[i] = &word[i].s.exp;
         end
         nanC[i] = expOnes[i] & (fracC[i] != '0);
      end
   end

   // execute stage register
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exeValid <= 1'b0;
         exeFmt   <= 1'b0;
         exeOp    <= '0;
         xSgn     <= 1'b0;
         ySgn     <= 1'b0;
         xExp     <= '0;
         yExp     <= '0;
         xMan     <= '0;
         yMan     <= '0;
         xZero    <= 1'b0;
         yZero    <= 1'b0;
         xNaN     <= 1'b0;
         yNaN     <= 1'b0;
         xSNaN    <= 1'b0;
         ySNaN    <= 1'b0;
         xSrc     <= '0;
         ySrc     <= '0;
      end else begin
         exeValid <= inValid;
         if (inValid) begin // hold payload between ops
            exeFmt <= fmt;
            exeOp  <= opCtrl;
            xSgn   <= sgnC[0];
            ySgn   <= sgnC[1];
            xExp   <= expC[0];
            yExp   <= expC[1];
            xMan   <= {|expC[0], fracC[0]}; // hidden bit unless subnormal
            yMan   <= {|expC[1], fracC[1]};
            xZero  <= (expC[0] == '0) & (fracC[0] == '0);
            yZero  <= (expC[1] == '0) & (fracC[1] == '0);
            xNaN   <= nanC[0];
            yNaN   <= nanC[1];
            xSNaN  <= nanC[0] & ~fracC[0][`NF-1]; // quiet bit clear
            ySNaN  <= nanC[1] & ~fracC[1][`NF-1];
            xSrc   <= word[0];
            ySrc   <= word[1];
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/fcmp.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_macros.svh"

module fcmp (
   input  wire logic              fmt,      // 1 double, 0 single
   input  wire logic [2:0]        opCtrl,   // OP_* codes
   input  wire logic              xSgn,
   input  wire logic              ySgn,
   input  wire logic [`NE-1:0]    xExp,
   input  wire logic [`NE-1:0]    yExp,
   input  wire logic [`NF:0]      xMan,     // with hidden bit
   input  wire logic [`NF:0]      yMan,
   input  wire logic              xZero,
   input  wire logic              yZero,
   input  wire logic              xNaN,
   input  wire logic              yNaN,
   input  wire logic              xSNaN,
   input  wire logic              ySNaN,
   input  wire fcmpPkg::fpWordT   xSrc,     // register words already boxed
   input  wire fcmpPkg::fpWordT   ySrc,
   output logic                   cmpNV,    // invalid for this op
   output fcmpPkg::fpWordT        cmpFpRes, // min/max result
   output logic [`XLEN-1:0]       cmpIntRes // eq/lt/le result
);

   logic            ltAbs;     // |x| < |y|
   logic            lt;
   logic            eq;
   logic            bothZero;
   logic            eitherNaN;
   logic            eitherSNaN;
   logic            ordBit;    // compare outcome before nan masking
   fcmpPkg::fpWordT nanRes;
   fcmpPkg::fpWordT minMax;

   // magnitude as unsigned integer with exponent above mantissa
   assign ltAbs = {xExp, xMan} < {yExp, yMan};

   // sign correction puts -0 below +0
   assign lt = (xSgn & ~ySgn) |
               (xSgn & ySgn & ~ltAbs & ~eq) |
               (~xSgn & ~ySgn & ltAbs);
   assign eq = (xSrc == ySrc);

   assign bothZero   = xZero & yZero; // +0 == -0
   assign eitherNaN  = xNaN | yNaN;
   assign eitherSNaN = xSNaN | ySNaN;

   // invalid flag
   always_comb begin
      case (opCtrl)
         `OP_MIN: cmpNV = eitherSNaN;
         `OP_MAX: cmpNV = eitherSNaN;
         `OP_EQ:  cmpNV = eitherSNaN; // quiet compare
         `OP_LT:  cmpNV = eitherNaN;  // signaling compare
         `OP_LE:  cmpNV = eitherNaN;
         default: cmpNV = 1'b0;
      endcase
   end

   // two nans give the canonical nan of the format
   assign nanRes = (fmt == `FMT_D) ? `QNAN_D : `QNAN_S;

   always_comb begin
      if (xNaN & yNaN)
         minMax = nanRes;
      else if (xNaN)
         minMax = ySrc; // single nan loses
      else if (yNaN)
         minMax = xSrc;
      else if (opCtrl[0])
         minMax = lt ? ySrc : xSrc; // max
      else
         minMax = lt ? xSrc : ySrc; // min
   end

   assign cmpFpRes = opCtrl[2] ? minMax : '0; // only min/max carry an fp result

   // bit 1 asks for equality and bit 0 for less than
   assign ordBit = ((eq | bothZero) & opCtrl[1]) | (lt & opCtrl[0] & ~bothZero);

   // unordered inputs and min/max give 0
   assign cmpIntRes = {{(`XLEN-1){1'b0}}, ordBit & ~eitherNaN & ~opCtrl[2]};

endmodule

`default_nettype wire

//--- hw/cmpRetire.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_macros.svh"

module cmpRetire (
   input  wire logic              clk,
   input  wire logic              arstN,
   input  wire logic              exeValid,  // op in execute stage
   input  wire logic              flagClr,   // software clear of accrued flag
   input  wire logic              cmpNV,
   input  wire fcmpPkg::fpWordT   cmpFpRes,
   input  wire logic [`XLEN-1:0]  cmpIntRes,
   output logic                   resValid,  // one pulse per op
   output fcmpPkg::fpWordT        fpRes,
   output logic [`XLEN-1:0]       intRes,
   output logic                   nvOut,
   output logic                   nvSticky
);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         resValid <= 1'b0;
         fpRes    <= '0;
         intRes   <= '0;
         nvOut    <= 1'b0;
      end else begin
         resValid <= exeValid;
         if (exeValid) begin // held until the next op
            fpRes  <= cmpFpRes;
            intRes <= cmpIntRes;
            nvOut  <= cmpNV;
         end
      end
   end

   // accrued invalid where a new flag beats the clear
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN)
         nvSticky <= 1'b0;
      else if (exeValid & cmpNV)
         nvSticky <= 1'b1;
      else if (flagClr)
         nvSticky <= 1'b0;
   end

endmodule

`default_nettype wire

//--- hw/fpCmpUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_macros.svh"

module fpCmpUnit (
   input  wire logic              clk,
   input  wire logic              arstN,
   input  wire logic              inValid,  // start an op
   input  wire logic              fmt,
   input  wire logic [2:0]        opCtrl,
   input  wire fcmpPkg::fpWordT   srcX,
   input  wire fcmpPkg::fpWordT   srcY,
   input  wire logic              flagClr,
   output logic                   resValid, // 2 cycles after inValid
   output fcmpPkg::fpWordT        fpRes,
   output logic [`XLEN-1:0]       intRes,
   output logic                   cmpNV,
   output logic                   nvSticky
);

   // execute stage
   logic                exeValid;
   logic                exeFmt;
   logic [2:0]          exeOp;
   logic                xSgn, ySgn;
   logic [`NE-1:0]      xExp, yExp;
   logic [`NF:0]        xMan, yMan;
   logic                xZero, yZero;
   logic                xNaN, yNaN;
   logic                xSNaN, ySNaN;
   fcmpPkg::fpWordT     xSrc, ySrc;

   // compare outputs into retire
   logic                exeNV;
   fcmpPkg::fpWordT     exeFpRes;
   logic [`XLEN-1:0]    exeIntRes;

   fpUnpack u_unpack (
      .clk      (clk),
      .arstN    (arstN),
      .inValid  (inValid),
      .fmt      (fmt),
      .opCtrl   (opCtrl),
      .srcX     (srcX),
      .srcY     (srcY),
      .exeValid (exeValid),
      .exeFmt   (exeFmt),
      .exeOp    (exeOp),
      .xSgn     (xSgn),
      .ySgn     (ySgn),
      .xExp     (xExp),
      .yExp     (yExp),
      .xMan     (xMan),
      .yMan     (yMan),
      .xZero    (xZero),
      .yZero    (yZero),
      .xNaN     (xNaN),
      .yNaN     (yNaN),
      .xSNaN    (xSNaN),
      .ySNaN    (ySNaN),
      .xSrc     (xSrc),
      .ySrc     (ySrc)
   );

   fcmp u_fcmp (
      .fmt       (exeFmt),
      .opCtrl    (exeOp),
      .xSgn      (xSgn),
      .ySgn      (ySgn),
      .xExp      (xExp),
      .yExp      (yExp),
      .xMan      (xMan),
      .yMan      (yMan),
      .xZero     (xZero),
      .yZero     (yZero),
      .xNaN      (xNaN),
      .yNaN      (yNaN),
      .xSNaN     (xSNaN),
      .ySNaN     (ySNaN),
      .xSrc      (xSrc),
      .ySrc      (ySrc),
      .cmpNV     (exeNV),
      .cmpFpRes  (exeFpRes),
      .cmpIntRes (exeIntRes)
   );

   cmpRetire u_retire (
      .clk       (clk),
      .arstN     (arstN),
      .exeValid  (exeValid),
      .flagClr   (flagClr),
      .cmpNV     (exeNV),
      .cmpFpRes  (exeFpRes),
      .cmpIntRes (exeIntRes),
      .resValid  (resValid),
      .fpRes     (fpRes),
      .intRes    (intRes),
      .nvOut     (cmpNV),
      .nvSticky  (nvSticky)
   );

endmodule

`default_nettype wire

//--- tests/fcmpVectors.svh
// directed rows issued back to back
// columns: op, fmt, srcX, srcY, flagClr, fpRes, intRes, cmpNV, nvSticky

localparam logic [`FLEN-1:0] dOne    = 64'h3FF0000000000000; // 1.0
localparam logic [`FLEN-1:0] dTwo    = 64'h4000000000000000; // 2.0
localparam logic [`FLEN-1:0] dNegOne = 64'hBFF0000000000000; // -1.0
localparam logic [`FLEN-1:0] posZero = 64'h0000000000000000;
localparam logic [`FLEN-1:0] negZero = 64'h8000000000000000;
localparam logic [`FLEN-1:0] dQnan   = `QNAN_D;
localparam logic [`FLEN-1:0] dSnan   = 64'h7FF4000000000000; // quiet bit clear
localparam logic [`FLEN-1:0] sOne    = 64'hFFFFFFFF3F800000;
localparam logic [`FLEN-1:0] sTwo    = 64'hFFFFFFFF40000000;
localparam logic [`FLEN-1:0] sBadBox = 64'h000000003F800000; // upper half not ones
localparam logic [`FLEN-1:0] sSnan   = 64'hFFFFFFFF7FA00000;
localparam logic [`FLEN-1:0] sQnan   = `QNAN_S;

task automatic loadTable();
   addRow(`OP_MIN, `FMT_D, dOne, dTwo, 0, dOne, 0, 0, 0);
   addRow(`OP_MAX, `FMT_D, dNegOne, dOne, 0, dOne, 0, 0, 0);
   addRow(`OP_EQ, `FMT_D, dOne, dOne, 0, 0, 1, 0, 0);
   addRow(`OP_LT, `FMT_D, dNegOne, dOne, 0, 0, 1, 0, 0);
   addRow(`OP_LE, `FMT_D, dTwo, dOne, 0, 0, 0, 0, 0);
   addRow(`OP_EQ, `FMT_D, negZero, posZero, 0, 0, 1, 0, 0);   // signed zeros equal
   addRow(`OP_MIN, `FMT_D, posZero, negZero, 0, negZero, 0, 0, 0);
   addRow(`OP_MAX, `FMT_D, negZero, posZero, 0, posZero, 0, 0, 0);
   addRow(`OP_MIN, `FMT_D, dQnan, dTwo, 0, dTwo, 0, 0, 0);   // nan loses
   addRow(`OP_MAX, `FMT_D, dQnan, dSnan, 0, dQnan, 0, 1, 1);
   addRow(`OP_EQ, `FMT_D, dQnan, dOne, 0, 0, 0, 0, 1);       // quiet nan leaves sticky set
   addRow(`OP_LT, `FMT_D, dOne, dQnan, 1, 0, 0, 1, 1);       // new flag beats clear
   addRow(`OP_EQ, `FMT_D, dOne, dTwo, 1, 0, 0, 0, 0);
   addRow(`OP_MIN, `FMT_S, sOne, sTwo, 0, sOne, 0, 0, 0);
   addRow(`OP_LE, `FMT_S, sOne, sTwo, 0, 0, 1, 0, 0);
   addRow(`OP_MIN, `FMT_S, sBadBox, sTwo, 0, sTwo, 0, 0, 0);
   addRow(`OP_MAX, `FMT_S, sBadBox, sSnan, 0, sQnan, 0, 1, 1);
   addRow(`OP_EQ, `FMT_S, sOne, sBadBox, 0, 0, 0, 0, 1);
   addRow(`OP_EQ, `FMT_S, sSnan, sSnan, 0, 0, 0, 1, 1);      // signaling nan flags eq
   addRow(`OP_LT, `FMT_S, sBadBox, sOne, 0, 0, 0, 1, 1);
   addRow(`OP_LE, `FMT_S, sTwo, sTwo, 1, 0, 1, 0, 0);
endtask

//--- tests/fcmpTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_macros.svh"

module fcmpTb;

   localparam int NRAND = 16;
   localparam int NMAX = 64;
   localparam logic [14:0] OPS = {`OP_MIN, `OP_MAX, `OP_EQ, `OP_LT, `OP_LE};

   logic                clk;
   logic                arstN;
   logic                inValid;
   logic                fmt;
   logic [2:0]          opCtrl;
   fcmpPkg::fpWordT     srcX;
   fcmpPkg::fpWordT     srcY;
   logic                flagClr;
   logic                resValid;
   fcmpPkg::fpWordT     fpRes;
   logic [`XLEN-1:0]    intRes;
   logic                cmpNV;
   logic                nvSticky;

   typedef struct {
      logic [2:0]       op;
      logic             fmt;
      fcmpPkg::fpWordT  x;
      fcmpPkg::fpWordT  y;
      logic             clr;   // flagClr at this row's retire edge
      fcmpPkg::fpWordT  eFp;
      logic [`XLEN-1:0] eInt;
      logic             eNv;
      logic             eSt;   // nvSticky after retire
   } rowT;

   rowT    rows [NMAX];
   int     nRows = 0;
   int     cyc = 0;           // rising edges so far
   int     passCnt = 0;
   int     failCnt = 0;
   int     curRow;
   logic   rowErr;
   integer seed = 32'h5abf;
   int     dueQ [$];          // cycle each result is due
   int     rowQ [$];

   fpCmpUnit u_dut (.*);

   task automatic addRow(input logic [2:0] op, input logic f, input fcmpPkg::fpWordT x,
                         input fcmpPkg::fpWordT y, input logic clr,
                         input fcmpPkg::fpWordT eFp, input logic [`XLEN-1:0] eInt,
                         input logic eNv, input logic eSt);
      rows[nRows] = '{op, f, x, y, clr, eFp, eInt, eNv, eSt};
      nRows++;
   endtask

   `include "fcmpVectors.svh"

   function automatic fcmpPkg::fpWordT randDouble();
      fcmpPkg::fpWordT w;
      w = {$random(seed), $random(seed)};
      w.d.exp = $unsigned($random(seed)) % 2047; // never all ones so no nan
      return w;
   endfunction

   // expected values from real-number ordering
   task automatic addRandom();
      fcmpPkg::fpWordT  x;
      fcmpPkg::fpWordT  y;
      fcmpPkg::fpWordT  eFp;
      logic [`XLEN-1:0] eInt;
      logic [2:0]       op;
      logic             xFirst;
      real              rx;
      real              ry;
      int               k;
      x = randDouble();
      y = randDouble();
      if (($random(seed) & 3) == 0)
         y = x; // some equal pairs
      k = $unsigned($random(seed)) % 5;
      op = OPS[3*k +: 3];
      rx = $bitstoreal(x);
      ry = $bitstoreal(y);
      xFirst = (rx < ry) || (rx == ry && x.d.sgn); // -0 below +0
      eFp = '0;
      eInt = '0;
      case (op)
         `OP_MIN: eFp = xFirst ? x : y;
         `OP_MAX: eFp = xFirst ? y : x;
         `OP_EQ:  eInt = (rx == ry);
         `OP_LT:  eInt = (rx < ry);
         default: eInt = (rx <= ry);
      endcase
      addRow(op, `FMT_D, x, y, 1'b0, eFp, eInt, 1'b0, rows[nRows-1].eSt);
   endtask

   task automatic checkFp(input fcmpPkg::fpWordT got, input fcmpPkg::fpWordT exp,
                          input string what);
      if (got !== exp) begin
         $display("FAIL %0t: row %0d %s is %h, expected %h", $time, curRow, what, got, exp);
         rowErr = 1'b1;
      end
   endtask

   task automatic checkInt(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                           input string what);
      if (got !== exp) begin
         $display("FAIL %0t: row %0d %s is %0d, expected %0d", $time, curRow, what, got, exp);
         rowErr = 1'b1;
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: row %0d %s is %b, expected %b", $time, curRow, what, got, exp);
         rowErr = 1'b1;
      end
   endtask

   task automatic checkCycle();
      if (dueQ.size() != 0 && dueQ[0] == cyc) begin
         curRow = rowQ[0];
         void'(dueQ.pop_front());
         void'(rowQ.pop_front());
         if (!resValid) begin
            $display("row %0d: no resValid 2 cycles after issue", curRow);
            failCnt++;
         end else begin
            rowErr = 1'b0;
            checkFp(fpRes, rows[curRow].eFp, "fpRes");
            checkInt(intRes, rows[curRow].eInt, "intRes");
            checkFlag(cmpNV, rows[curRow].eNv, "cmpNV");
            checkFlag(nvSticky, rows[curRow].eSt, "nvSticky");
            $display("row %0d op %b fmt %b %s", curRow, rows[curRow].op, rows[curRow].fmt,
                     rowErr ? "bad" : "ok");
            if (rowErr)
               failCnt++;
            else
               passCnt++;
         end
      end else if (resValid) begin
         $display("resValid high at cycle %0d with no operation due", cyc);
         failCnt++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // outputs settled by the falling edge
   always @(negedge clk) begin
      if (arstN)
         checkCycle();
   end

   initial begin
      arstN   = 1'b0;
      inValid = 1'b0;
      fmt     = `FMT_D;
      opCtrl  = '0;
      srcX    = '0;
      srcY    = '0;
      flagClr = 1'b0;
      loadTable();
      for (int i = 0; i < NRAND; i++)
         addRandom();
      repeat (5) @(posedge clk);
      arstN <= 1'b1;
      for (int i = 0; i < nRows; i++) begin
         @(posedge clk);
         inValid <= 1'b1;
         opCtrl  <= rows[i].op;
         fmt     <= rows[i].fmt;
         srcX    <= rows[i].x;
         srcY    <= rows[i].y;
         flagClr <= (i > 0) ? rows[i-1].clr : 1'b0; // lands on previous row's retire edge
         dueQ.push_back(cyc + 3); // cyc not yet bumped for this edge
         rowQ.push_back(i);
      end
      @(posedge clk);
      inValid <= 1'b0;
      flagClr <= rows[nRows-1].clr;
      @(posedge clk);
      flagClr <= 1'b0;
      while (dueQ.size() != 0)
         @(negedge clk);
      repeat (2) @(posedge clk); // catch a stray resValid
      $display("rows passed %0d, failed %0d", passCnt, failCnt);
      if (failCnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // watchdog sized from the row count
   initial begin
      #1;
      #((nRows + 20) * 8);
      $display("timeout: results did not all arrive");
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
+incdir+tests
hw/fcmpPkg.sv
hw/fpUnpack.sv
hw/fcmp.sv
hw/cmpRetire.sv
hw/fpCmpUnit.sv
tests/fcmpTb.sv
